// ==== hdl/vlc_pkg.sv ====
// ----------------------------------------------------------------------
// vlc packer shared definitions: symbol word layout, commands, apb map
// ----------------------------------------------------------------------
package vlc_pkg;

    localparam int sym_w   = 32;                // symbol and output word width
    localparam int len_w   = 5;                 // code length field
    localparam int code_w  = 27;                // msb aligned code field
    localparam int cmd_w   = 3;                 // control command field
    localparam int rsvd_w  = sym_w - len_w - cmd_w;
    localparam int bytes_w = 3;                 // byte count 0..4
    localparam int level_w = 8;                 // fifo fill level
    localparam int addr_w  = 4;                 // apb address

    typedef struct packed {
        logic [len_w-1:0]  len;                 // 1..27
        logic [code_w-1:0] code;                // bits below len are don't care
    } sym_code_t;

    typedef struct packed {
        logic [len_w-1:0]  len;                 // zero marks a control word
        logic [cmd_w-1:0]  cmd;
        logic [rsvd_w-1:0] rsvd;
    } sym_ctrl_t;

    // one input word, two views selected by the length field
    typedef union packed {
        sym_code_t code;
        sym_ctrl_t ctrl;
    } sym_word_u;

    localparam logic [cmd_w-1:0] cmd_flush = 3'd1; // close block, other codes ignored

    localparam logic [addr_w-1:0] reg_status = 4'h0; // level, overflow, empty
    localparam logic [addr_w-1:0] reg_info   = 4'h4; // head byte count and last flag
    localparam logic [addr_w-1:0] reg_data   = 4'h8; // head word, read pops

    localparam int st_ovf_bit   = 8;            // sticky, write 1 to clear
    localparam int st_empty_bit = 9;

endpackage

// ==== hdl/bit_stuffer.sv ====
// ----------------------------------------------------------------------
// bit stuffer: packs msb aligned codes of 1..27 bits into 32-bit words
// ----------------------------------------------------------------------
module bit_stuffer (
    input  logic                        xclk,
    input  logic                        rst,
    input  vlc_pkg::sym_word_u          sym,       // code or control word
    input  logic                        sym_valid,
    output logic [vlc_pkg::sym_w-1:0]   wdata,
    output logic [vlc_pkg::bytes_w-1:0] wbytes,    // 4 for full words
    output logic                        wlast,     // set on the flush word
    output logic                        wvalid     // single cycle push
);
    import vlc_pkg::*;

    localparam int pos_w = $clog2(sym_w);          // bit position in the word
    localparam int d1_w  = code_w + 24;            // after byte shift
    localparam int d2_w  = d1_w + 6;               // after 2-bit shift
    localparam int d3_w  = d2_w + 1;               // after 1-bit shift
    localparam int lo_w  = d3_w - sym_w;           // spill into the next word

    logic [code_w-1:0] code_mask;
    logic [code_w-1:0] code_in;
    logic              take_code;
    logic              take_flush;
    logic [pos_w:0]    pos_sum;
    logic [pos_w-1:0]  pos;                        // running position mod 32

    logic              v1;
    logic              f1;
    logic              c1;
    logic [pos_w-1:0]  s1;
    logic [d1_w-1:0]   data1;

    logic              v2;
    logic              f2;
    logic              c2;
    logic [pos_w-1:0]  s2;
    logic [d2_w-1:0]   data2;
    logic [sym_w-1:0]  mask2;

    logic [d3_w-1:0]   data3;
    logic [sym_w-1:0]  merged;
    logic [sym_w-1:0]  hold;                       // partial word, zero past pos
    logic [pos_w:0]    flush_bits;

    assign take_code  = sym_valid && (sym.code.len != '0);
    assign take_flush = sym_valid && (sym.ctrl.len == '0) && (sym.ctrl.cmd == cmd_flush);

    // keep only the top len bits so the residue pads with zeros
    assign code_mask = ~({code_w{1'b1}} >> sym.code.len);
    assign code_in   = sym.code.code & code_mask;
    assign pos_sum   = {1'b0, pos} + (pos_w + 1)'(sym.code.len); // msb is word carry

    always_ff @(posedge xclk) begin
        if (rst) begin
            pos <= '0;
            v1  <= 1'b0;
            f1  <= 1'b0;
            c1  <= 1'b0;
            v2  <= 1'b0;
            f2  <= 1'b0;
            c2  <= 1'b0;
        end else begin
            if (take_flush) begin
                pos <= '0;                         // next block starts at bit 0
            end else if (take_code) begin
                pos <= pos_sum[pos_w-1:0];
            end
            v1 <= take_code;
            f1 <= take_flush;
            c1 <= take_code && pos_sum[pos_w];
            v2 <= v1;
            f2 <= f1;
            c2 <= c1;
        end
    end

    // stage 1 byte shift, stage 2 two-bit shift and fill mask
    always_ff @(posedge xclk) begin
        s1    <= pos;                              // start position of this symbol
        data1 <= {code_in, 24'b0} >> (8 * pos[pos_w-1:3]);
        s2    <= s1;
        data2 <= {data1, 6'b0} >> (2 * s1[2:1]);
        mask2 <= {sym_w{1'b1}} >> s1;              // ones from start position on
    end

    // stage 3 one-bit shift, merged straight into the hold register
    assign data3      = {data2, 1'b0} >> s2[0];
    assign merged     = (hold & ~mask2) | (data3[d3_w-1 -: sym_w] & mask2);
    assign flush_bits = {1'b0, s2} + (pos_w + 1)'(7); // round bits up to bytes

    always_ff @(posedge xclk) begin
        if (rst) begin
            hold   <= '0;
            wvalid <= 1'b0;
            wbytes <= '0;
            wlast  <= 1'b0;
        end else begin
            wvalid <= (v2 && c2) || f2;
            if (f2) begin
                hold   <= '0;
                wbytes <= flush_bits[pos_w:3];     // 0 means end marker
                wlast  <= 1'b1;
            end else if (v2) begin
                if (c2) begin
                    hold <= {data3[lo_w-1:0], {(sym_w - lo_w){1'b0}}}; // carry spill
                end else begin
                    hold <= merged;
                end
                wbytes <= bytes_w'(4);
                wlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (f2) begin
            wdata <= hold;                         // residue, already zero padded
        end else if (v2 && c2) begin
            wdata <= merged;                       // word completed by this code
        end
    end

endmodule

// ==== hdl/word_fifo.sv ====
// ----------------------------------------------------------------------
// word fifo: packed words with byte count and last flag, drops on full
// ----------------------------------------------------------------------
module word_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        xclk,
    input  logic                        rst,
    input  logic [vlc_pkg::sym_w-1:0]   wdata,
    input  logic [vlc_pkg::bytes_w-1:0] wbytes,
    input  logic                        wlast,
    input  logic                        wvalid,
    output logic [vlc_pkg::sym_w-1:0]   rdata,     // head entry
    output logic [vlc_pkg::bytes_w-1:0] rbytes,
    output logic                        rlast,
    input  logic                        pop,
    output logic [vlc_pkg::level_w-1:0] level,
    output logic                        empty,
    output logic                        overflow   // one cycle per dropped word
);
    import vlc_pkg::*;

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int ent_w = 1 + bytes_w + sym_w;

    logic [ent_w-1:0]   mem [FIFO_DEPTH];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [level_w-1:0] count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(FIFO_DEPTH - 1)) begin
            return '0;                             // wrap for any depth
        end
        return p + 1'b1;
    endfunction

    assign full    = (count == level_w'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_pop  = pop && !empty;
    assign do_push = wvalid && (!full || do_pop);  // a pop frees the slot this cycle
    assign level   = count;

    assign {rlast, rbytes, rdata} = mem[rd_ptr];

    always_ff @(posedge xclk) begin
        if (do_push) begin
            mem[wr_ptr] <= {wlast, wbytes, wdata};
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wvalid && !do_push;
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

endmodule

// ==== hdl/apb_readout.sv ====
// ----------------------------------------------------------------------
// apb readout: fifo status, head entry info and popping word reads
// ----------------------------------------------------------------------
module apb_readout #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        xclk,
    input  logic                        rst,
    input  logic [vlc_pkg::addr_w-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [vlc_pkg::sym_w-1:0]   pwdata,
    output logic [vlc_pkg::sym_w-1:0]   prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic [vlc_pkg::sym_w-1:0]   rdata,
    input  logic [vlc_pkg::bytes_w-1:0] rbytes,
    input  logic                        rlast,
    input  logic [vlc_pkg::level_w-1:0] level,
    input  logic                        empty,
    input  logic                        overflow,
    output logic                        pop
);
    import vlc_pkg::*;

    logic access;
    logic rd_sel;
    logic hit_status;
    logic hit_info;
    logic hit_data;
    logic ovf_flag;                                // sticky overflow

    // level field is 8 bits wide
    if (FIFO_DEPTH < 2 || FIFO_DEPTH > 128) begin : g_depth_range
        $error("FIFO_DEPTH must be within 2..128");
    end

    assign access     = psel && penable;
    assign rd_sel     = psel && !pwrite;
    assign hit_status = (paddr == reg_status);
    assign hit_info   = (paddr == reg_info);
    assign hit_data   = (paddr == reg_data);

    assign pready  = 1'b1;                         // no wait states
    assign pop     = access && !pwrite && hit_data && !empty;
    assign pslverr = access && (!(hit_status || hit_info || hit_data)
                                || (hit_data && !pwrite && empty)
                                || (pwrite && !hit_status));

    always_ff @(posedge xclk) begin
        if (rst) begin
            ovf_flag <= 1'b0;
        end else if (overflow) begin
            ovf_flag <= 1'b1;                      // a new drop wins over a clear
        end else if (access && pwrite && hit_status && pwdata[st_ovf_bit]) begin
            ovf_flag <= 1'b0;
        end
    end

    always_comb begin
        prdata = '0;
        if (rd_sel) begin
            case (paddr)
                reg_status: begin
                    prdata[level_w-1:0]  = level;
                    prdata[st_ovf_bit]   = ovf_flag;
                    prdata[st_empty_bit] = empty;
                end
                reg_info: prdata[bytes_w:0] = {rlast, rbytes}; // no side effect
                reg_data: prdata = rdata;
                default:  prdata = '0;
            endcase
        end
    end

endmodule

// ==== hdl/vlc_packer_top.sv ====
// ----------------------------------------------------------------------
// vlc packer top: bit stuffer into word fifo, read out over apb
// ----------------------------------------------------------------------
module vlc_packer_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                       xclk,
    input  logic                       rst,
    input  vlc_pkg::sym_word_u         sym,
    input  logic                       sym_valid,
    input  logic [vlc_pkg::addr_w-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [vlc_pkg::sym_w-1:0]  pwdata,
    output logic [vlc_pkg::sym_w-1:0]  prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import vlc_pkg::*;

    logic [sym_w-1:0]   wdata;                     // stuffer push side
    logic [bytes_w-1:0] wbytes;
    logic               wlast;
    logic               wvalid;
    logic [sym_w-1:0]   rdata;                     // fifo head
    logic [bytes_w-1:0] rbytes;
    logic               rlast;
    logic               pop;
    logic [level_w-1:0] level;
    logic               empty;
    logic               overflow;

    bit_stuffer bit_stuffer_inst (
        .xclk      (xclk),
        .rst       (rst),
        .sym       (sym),
        .sym_valid (sym_valid),
        .wdata     (wdata),
        .wbytes    (wbytes),
        .wlast     (wlast),
        .wvalid    (wvalid)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) word_fifo_inst (
        .xclk     (xclk),
        .rst      (rst),
        .wdata    (wdata),
        .wbytes   (wbytes),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .rdata    (rdata),
        .rbytes   (rbytes),
        .rlast    (rlast),
        .pop      (pop),
        .level    (level),
        .empty    (empty),
        .overflow (overflow)
    );

    apb_readout #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) apb_readout_inst (
        .xclk     (xclk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .rdata    (rdata),
        .rbytes   (rbytes),
        .rlast    (rlast),
        .level    (level),
        .empty    (empty),
        .overflow (overflow),
        .pop      (pop)
    );

endmodule

// ==== tb/vlc_packer_checker.sv ====
// ----------------------------------------------------------------------
// vlc packer assertions: push byte count, apb ready, pop and reset
// ----------------------------------------------------------------------
module vlc_packer_checker (
    input logic                        xclk,
    input logic                        rst,
    input logic [vlc_pkg::bytes_w-1:0] wbytes,
    input logic                        wvalid,
    input logic                        pready,
    input logic                        pop,
    input logic                        empty
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;                            // failed assertions so far

    a_wbytes_range: assert property (@(posedge xclk) disable iff (rst) wbytes <= 3'd4)
        else begin
            $error("push byte count above 4");
            fail_count++;
        end

    a_pready_high: assert property (@(posedge xclk) disable iff (rst) pready)
        else begin
            $error("pready dropped, apb slave has no wait states");
            fail_count++;
        end

    a_pop_not_empty: assert property (@(posedge xclk) disable iff (rst) pop |-> !empty)
        else begin
            $error("pop while fifo empty");
            fail_count++;
        end

    // first cycle out of reset, pipeline must be quiet
    a_wvalid_after_rst: assert property (@(posedge xclk) $fell(rst) |-> !wvalid)
        else begin
            $error("push strobe in the cycle after reset");
            fail_count++;
        end

endmodule

bind vlc_packer_top vlc_packer_checker checker_inst (
    .xclk   (xclk),
    .rst    (rst),
    .wbytes (wbytes),
    .wvalid (wvalid),
    .pready (pready),
    .pop    (pop),
    .empty  (empty)
);

// ==== tb/vlc_packer_tb.sv ====
// ----------------------------------------------------------------------
// vlc packer testbench: lfsr symbols, bit queue model, apb readout checks
// ----------------------------------------------------------------------
module vlc_packer_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vlc_pkg::*;

    localparam int depth     = 16;
    localparam int n_rand    = 18;                 // at most 486 bits, fits the fifo
    localparam int n_ovf     = 2 * (depth + 4);    // 16-bit codes, 4 words dropped
    localparam int sym_total = n_rand + 7 + 17 + n_ovf + 2;
    localparam int apb_total = 3 * (n_rand + depth + 8) + 24;
    localparam longint watchdog_ns = longint'(sym_total + apb_total) * 64 * 8;

    logic               xclk;
    logic               rst;
    sym_word_u          sym;
    logic               sym_valid;
    logic [addr_w-1:0]  paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [sym_w-1:0]   pwdata;
    logic [sym_w-1:0]   prdata;
    logic               pready;
    logic               pslverr;

    bit                 bq[$];                     // pending model bits, msb first
    logic [sym_w-1:0]   exp_word[$];
    logic [bytes_w:0]   exp_info[$];               // {last, bytes}
    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 base_errors;

    vlc_packer_top #(
        .FIFO_DEPTH (depth)
    ) vlc_packer_top_inst (
        .xclk      (xclk),
        .rst       (rst),
        .sym       (sym),
        .sym_valid (sym_valid),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        xclk = 1'b0;
        forever #4 xclk = ~xclk;                   // 8 ns period
    end

    initial begin
        #(watchdog_ns);
        $display("error: watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1); // galois, right shift
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                // one step per bit
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic void model_code(input logic [len_w-1:0] len,
                                       input logic [code_w-1:0] code);
        logic [sym_w-1:0] w;
        for (int i = 0; i < int'(len); i++) begin
            bq.push_back(code[code_w-1-i]);        // top len bits only
        end
        while (bq.size() >= sym_w) begin
            w = '0;
            for (int i = 0; i < sym_w; i++) begin
                w[sym_w-1-i] = bq.pop_front();
            end
            exp_word.push_back(w);
            exp_info.push_back({1'b0, 3'd4});      // full word
        end
    endfunction

    function automatic void model_flush();
        int               n;
        logic [sym_w-1:0] w;
        n = bq.size();
        w = '0;                                    // zero padding below residue
        for (int i = 0; i < n; i++) begin
            w[sym_w-1-i] = bq.pop_front();
        end
        exp_word.push_back(w);
        exp_info.push_back({1'b1, bytes_w'((n + 7) / 8)}); // 0 bytes is end marker
    endfunction

    task automatic send_sym(input sym_word_u s, input int gap);
        @(posedge xclk);
        sym       <= s;
        sym_valid <= 1'b1;
        repeat (gap) begin
            @(posedge xclk);
            sym_valid <= 1'b0;
        end
    endtask

    task automatic send_idle();
        @(posedge xclk);
        sym_valid <= 1'b0;
    endtask

    task automatic send_code(input logic [len_w-1:0] len, input logic [code_w-1:0] code,
                             input int gap);
        sym_word_u s;
        s.code.len  = len;
        s.code.code = code;                        // low bits random, must be ignored
        send_sym(s, gap);
        model_code(len, code);
    endtask

    task automatic send_ctrl(input logic [cmd_w-1:0] cmd, input int gap);
        sym_word_u s;
        s.ctrl.len  = '0;
        s.ctrl.cmd  = cmd;
        s.ctrl.rsvd = rsvd_w'(take_bits(rsvd_w));
        send_sym(s, gap);
        if (cmd == cmd_flush) begin
            model_flush();
        end
    endtask

    task automatic apb_read(input logic [addr_w-1:0] addr, output logic [sym_w-1:0] data,
                            output logic err);
        @(posedge xclk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;                           // setup phase
        penable <= 1'b0;
        @(posedge xclk);
        penable <= 1'b1;
        @(negedge xclk);
        data = prdata;                             // mid access phase
        err  = pslverr;
        @(posedge xclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [addr_w-1:0] addr, input logic [sym_w-1:0] data,
                             output logic err);
        @(posedge xclk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge xclk);
        penable <= 1'b1;
        @(negedge xclk);
        err = pslverr;
        @(posedge xclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_word(input string name, input logic [sym_w-1:0] exp,
                              input logic [sym_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s word: expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_info(input string name, input logic [bytes_w-1:0] exp_bytes,
                              input logic exp_last, input logic [bytes_w-1:0] act_bytes,
                              input logic act_last);
        checks++;
        if ({act_last, act_bytes} !== {exp_last, exp_bytes}) begin
            errors++;
            $display("mismatch %s info: expected bytes %0d last %0b actual bytes %0d last %0b",
                     name, exp_bytes, exp_last, act_bytes, act_last);
        end
    endtask

    task automatic check_status(input string name, input logic [level_w-1:0] exp_level,
                                input logic exp_ovf, input logic exp_empty,
                                input logic [level_w-1:0] act_level, input logic act_ovf,
                                input logic act_empty);
        string exp_s;
        string act_s;
        checks++;
        if ({act_level, act_ovf, act_empty} !== {exp_level, exp_ovf, exp_empty}) begin
            errors++;
            exp_s = $sformatf("level %0d ovf %0b empty %0b", exp_level, exp_ovf, exp_empty);
            act_s = $sformatf("level %0d ovf %0b empty %0b", act_level, act_ovf, act_empty);
            $display("mismatch %s status: expected %s actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic expect_err(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            if (exp) begin
                $display("error: %s: pslverr was not raised", name);
            end else begin
                $display("error: %s: pslverr raised on a valid transfer", name);
            end
        end
    endtask

    task automatic status_is(input string name, input logic [level_w-1:0] lvl,
                             input logic ovf, input logic emp);
        logic [sym_w-1:0] d;
        logic             e;
        apb_read(reg_status, d, e);
        check_status(name, lvl, ovf, emp, d[level_w-1:0], d[st_ovf_bit], d[st_empty_bit]);
    endtask

    task automatic wait_level();
        logic [sym_w-1:0] d;
        logic             e;
        d = '0;
        while (d[level_w-1:0] == '0) begin         // latency depends on the fill
            apb_read(reg_status, d, e);
        end
    endtask

    task automatic read_word(input string name);
        logic [sym_w-1:0] d;
        logic             e;
        wait_level();
        apb_read(reg_info, d, e);
        check_info(name, exp_info[0][bytes_w-1:0], exp_info[0][bytes_w], d[bytes_w-1:0],
                   d[bytes_w]);
        apb_read(reg_data, d, e);                  // pops the head
        expect_err(name, 1'b0, e);
        check_word(name, exp_word.pop_front(), d);
        exp_info.delete(0);
    endtask

    task automatic drain(input string name);
        while (exp_word.size() > 0) begin
            read_word(name);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %s, %0d errors", name, (errors == base_errors) ? "ok" : "bad",
                 errors - base_errors);
        base_errors = errors;
    endtask

    initial begin
        logic [sym_w-1:0] d;
        logic             e;
        rst         = 1'b1;
        sym         = '0;
        sym_valid   = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        lfsr        = 32'h8c55_0c18;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        base_errors = 0;
        repeat (10) @(posedge xclk);
        rst <= 1'b0;

        status_is("reset", '0, 1'b0, 1'b1);
        end_test("reset");

        for (int i = 0; i < n_rand; i++) begin     // random lengths and gaps
            send_code(len_w'(1 + take_bits(5) % code_w), code_w'(take_bits(code_w)),
                      int'(take_bits(2)));
        end
        send_ctrl(cmd_flush, 0);
        send_idle();
        drain("random_block");
        status_is("random_block", '0, 1'b0, 1'b1);
        end_test("random_block");

        send_code(5'd27, code_w'(take_bits(code_w)), 0); // 64 bits, ends on a boundary
        send_code(5'd27, code_w'(take_bits(code_w)), 1);
        send_code(5'd10, code_w'(take_bits(code_w)), 0);
        send_ctrl(cmd_flush, 0);                   // end marker
        send_code(5'd5, code_w'(take_bits(code_w)), 0); // new block from bit 0
        send_ctrl(cmd_flush, 0);
        send_idle();
        drain("boundary_flush");
        end_test("boundary_flush");

        for (int c = 0; c < 8; c++) begin
            if (cmd_w'(c) != cmd_flush) begin
                send_ctrl(cmd_w'(c), 1);
            end
        end
        send_idle();
        repeat (8) @(posedge xclk);
        status_is("ignored_cmds", '0, 1'b0, 1'b1);
        for (int i = 0; i < 6; i++) begin
            send_code(len_w'(1 + take_bits(5) % code_w), code_w'(take_bits(code_w)), 0);
            if (i % 2 == 0) begin
                send_ctrl((i % 4 == 0) ? 3'd0 : 3'd7, 0);
            end
        end
        send_ctrl(cmd_flush, 0);
        send_idle();
        drain("ignored_cmds");
        end_test("ignored_cmds");

        for (int i = 0; i < n_ovf; i++) begin      // no reads, fifo fills up
            send_code(5'd16, code_w'(take_bits(code_w)), 0);
        end
        send_idle();
        repeat (8) @(posedge xclk);
        status_is("overflow", level_w'(depth), 1'b1, 1'b0);
        for (int i = 0; i < depth; i++) begin
            read_word("overflow");
        end
        exp_word.delete();                         // dropped words
        exp_info.delete();
        status_is("overflow", '0, 1'b1, 1'b1);
        apb_write(reg_status, 32'h100, e);         // clear sticky flag
        expect_err("overflow", 1'b0, e);
        status_is("overflow", '0, 1'b0, 1'b1);
        end_test("overflow");

        send_code(5'd16, code_w'(take_bits(code_w)), 0);
        send_code(5'd16, code_w'(take_bits(code_w)), 0);
        send_idle();
        wait_level();
        apb_read(4'hc, d, e);                      // unmapped
        expect_err("slave_errors", 1'b1, e);
        apb_write(reg_info, 32'hf, e);             // read only register
        expect_err("slave_errors", 1'b1, e);
        status_is("slave_errors", 8'd1, 1'b0, 1'b0);
        read_word("slave_errors");
        apb_read(reg_data, d, e);                  // pop while empty
        expect_err("slave_errors", 1'b1, e);
        status_is("slave_errors", '0, 1'b0, 1'b1);
        end_test("slave_errors");

        errors = errors + vlc_packer_top_inst.checker_inst.fail_count;
        $display("tests %0d, checks %0d, errors %0d (assertion failures %0d)", tests, checks,
                 errors, vlc_packer_top_inst.checker_inst.fail_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/vlc_pkg.sv
hdl/bit_stuffer.sv
hdl/word_fifo.sv
hdl/apb_readout.sv
hdl/vlc_packer_top.sv
tb/vlc_packer_checker.sv
tb/vlc_packer_tb.sv

// ==== Makefile ====
# Verilator build for the vlc packer: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= vlc_packer_tb
RTL_TOP   ?= vlc_packer_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Test completed successfully

RTL_SRCS := hdl/vlc_pkg.sv hdl/bit_stuffer.sv hdl/word_fifo.sv \
            hdl/apb_readout.sv hdl/vlc_packer_top.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
